// File: soc_cfg_pkg.sv
package soc_cfg_pkg;

   ////////////////////////////////
   // System sizing defaults
   ////////////////////////////////

   // Memory word width in bits
   localparam int word_bits_c = 32;

   // Number of words in the command memory
   localparam int mem_words_c = 16;

   // sysclk cycles per UART bit
   localparam int baud_div_c = 8;

   // Cycles of internal reset after the external one goes away
   localparam int reset_hold_c = 16;

   // Entries per byte FIFO, enough for one full read reply
   localparam int fifo_depth_c = 4;

endpackage

// File: cmd_pkg.sv
package cmd_pkg;

   ////////////////////////////////
   // Data types
   ////////////////////////////////

   // One UART character
   typedef logic [7:0] byte_t;

   // Memory word, sent as four bytes LSB first
   typedef logic [31:0] word_t;

   ////////////////////////////////
   // Host command opcodes
   ////////////////////////////////

   // 'W' then address, then four data bytes
   localparam byte_t op_write_c = 8'h57;

   // 'R' then address, four bytes come back
   localparam byte_t op_read_c = 8'h52;

endpackage

// File: por_reset.sv
`timescale 1ns/1ps

module por_reset #(
   parameter int RESET_HOLD = 16
) (
   input  logic sysclk,
   input  logic reset,
   output logic sys_reset
);

   localparam int CW = $clog2(RESET_HOLD + 1);

   logic [CW-1:0] hold_cnt;

   // Counts up once reset is gone and then sticks
   always_ff @(posedge sysclk or posedge reset) begin
      if (reset) begin
         hold_cnt  <= '0;
         sys_reset <= 1'b1;
      end else begin
         if (hold_cnt != CW'(RESET_HOLD)) begin
            hold_cnt <= hold_cnt + 1'b1;
         end
         sys_reset <= (hold_cnt != CW'(RESET_HOLD));
      end
   end

endmodule

// File: uart_rx.sv
`timescale 1ns/1ps

module uart_rx import cmd_pkg::*; #(
   parameter int BAUD_DIV = 8
) (
   input  logic  sysclk,
   input  logic  reset,
   input  logic  rxd,
   output byte_t rx_byte,
   output logic  rx_valid
);

   localparam int CW = $clog2(BAUD_DIV + 1);

   typedef enum logic [1:0] {
      rx_idle,
      rx_start,
      rx_data,
      rx_stop
   } rx_state_t;

   rx_state_t     state;
   logic [1:0]    rx_sync;
   logic [CW-1:0] baud_cnt;
   logic [2:0]    bit_cnt;
   byte_t         shift_q;

   wire rx_s = rx_sync[1];

   // Line idles high
   always_ff @(posedge sysclk or posedge reset) begin
      if (reset) begin
         rx_sync <= 2'b11;
      end else begin
         rx_sync <= {rx_sync[0], rxd};
      end
   end

   always_ff @(posedge sysclk or posedge reset) begin
      if (reset) begin
         state    <= rx_idle;
         baud_cnt <= '0;
         bit_cnt  <= '0;
         rx_valid <= 1'b0;
      end else begin
         rx_valid <= 1'b0;
         unique case (state)
            rx_idle: begin
               if (!rx_s) begin
                  state    <= rx_start;
                  baud_cnt <= CW'(BAUD_DIV / 2 - 1);
               end
            end
            rx_start: begin
               if (baud_cnt != '0) begin
                  baud_cnt <= baud_cnt - 1'b1;
               end else if (!rx_s) begin
                  // Still low at mid start bit
                  state    <= rx_data;
                  baud_cnt <= CW'(BAUD_DIV - 1);
                  bit_cnt  <= '0;
               end else begin
                  state <= rx_idle;
               end
            end
            rx_data: begin
               if (baud_cnt != '0) begin
                  baud_cnt <= baud_cnt - 1'b1;
               end else begin
                  baud_cnt <= CW'(BAUD_DIV - 1);
                  bit_cnt  <= bit_cnt + 1'b1;
                  if (bit_cnt == 3'd7) begin
                     state <= rx_stop;
                  end
               end
            end
            rx_stop: begin
               if (baud_cnt != '0) begin
                  baud_cnt <= baud_cnt - 1'b1;
               end else begin
                  // Framing error drops the byte
                  rx_valid <= rx_s;
                  state    <= rx_idle;
               end
            end
            default: state <= rx_idle;
         endcase
      end
   end

   // LSB arrives first
   always_ff @(posedge sysclk) begin
      if (state == rx_data && baud_cnt == '0) begin
         shift_q <= {rx_s, shift_q[7:1]};
      end
   end

   assign rx_byte = shift_q;

endmodule

// File: uart_tx.sv
`timescale 1ns/1ps

module uart_tx import cmd_pkg::*; #(
   parameter int BAUD_DIV = 8
) (
   input  logic  sysclk,
   input  logic  reset,
   input  byte_t tx_byte,
   input  logic  tx_empty,
   output logic  tx_pop,
   output logic  txd
);

   localparam int CW = $clog2(BAUD_DIV + 1);

   logic          busy;
   logic [9:0]    frame_q;
   logic [CW-1:0] baud_cnt;
   logic [3:0]    bit_cnt;

   // Take the next byte as soon as the line is free
   assign tx_pop = !busy && !tx_empty;

   always_ff @(posedge sysclk or posedge reset) begin
      if (reset) begin
         busy     <= 1'b0;
         frame_q  <= '1;
         baud_cnt <= '0;
         bit_cnt  <= '0;
      end else if (tx_pop) begin
         // Stop, data, start
         frame_q  <= {1'b1, tx_byte, 1'b0};
         busy     <= 1'b1;
         baud_cnt <= CW'(BAUD_DIV - 1);
         bit_cnt  <= '0;
      end else if (busy) begin
         if (baud_cnt != '0) begin
            baud_cnt <= baud_cnt - 1'b1;
         end else begin
            // Ones shift in, so the line rests high afterwards
            frame_q  <= {1'b1, frame_q[9:1]};
            baud_cnt <= CW'(BAUD_DIV - 1);
            bit_cnt  <= bit_cnt + 1'b1;
            if (bit_cnt == 4'd9) begin
               busy <= 1'b0;
            end
         end
      end
   end

   assign txd = frame_q[0];

endmodule

// File: byte_fifo.sv
`timescale 1ns/1ps

module byte_fifo import cmd_pkg::*; #(
   parameter int DEPTH = 4
) (
   input  logic  sysclk,
   input  logic  reset,
   input  byte_t wr_data,
   input  logic  push,
   input  logic  pop,
   output byte_t rd_data,
   output logic  empty,
   output logic  full
);

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int NW = $clog2(DEPTH + 1);

   byte_t         mem [DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [NW-1:0] count;

   wire do_push = push && !full;
   wire do_pop  = pop && !empty;

   always_ff @(posedge sysclk or posedge reset) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         if (do_push != do_pop) begin
            count <= do_push ? count + 1'b1 : count - 1'b1;
         end
      end
   end

   always_ff @(posedge sysclk) begin
      if (do_push) begin
         mem[wr_ptr] <= wr_data;
      end
   end

   // Head is visible while not empty
   assign rd_data = mem[rd_ptr];
   assign empty   = (count == '0);
   assign full    = (count == NW'(DEPTH));

endmodule

// File: word_ram.sv
`timescale 1ns/1ps

module word_ram import cmd_pkg::*; #(
   parameter int WORDS = 16
) (
   input  logic                     sysclk,
   input  logic                     reset,
   input  logic                     we,
   input  logic [$clog2(WORDS)-1:0] addr,
   input  word_t                    wdata,
   output word_t                    rdata
);

   word_t mem [WORDS];

   // Contents start at zero after every reset
   always_ff @(posedge sysclk or posedge reset) begin
      if (reset) begin
         for (int i = 0; i < WORDS; i++) begin
            mem[i] <= '0;
         end
      end else if (we) begin
         mem[addr] <= wdata;
      end
   end

   assign rdata = mem[addr];

endmodule

// File: cmd_ctrl.sv
`timescale 1ns/1ps

module cmd_ctrl import cmd_pkg::*; #(
   parameter int WORDS = 16
) (
   input  logic                     sysclk,
   input  logic                     reset,
   input  byte_t                    cmd_byte,
   input  logic                     cmd_empty,
   output logic                     cmd_pop,
   output logic                     mem_we,
   output logic [$clog2(WORDS)-1:0] mem_addr,
   output word_t                    mem_wdata,
   input  word_t                    mem_rdata,
   output byte_t                    rep_byte,
   output logic                     rep_push,
   input  logic                     rep_full,
   output logic                     trap
);

   localparam int AW = $clog2(WORDS);

   typedef enum logic [3:0] {
      st_opcode,
      st_addr,
      st_data0,
      st_data1,
      st_data2,
      st_data3,
      st_reply0,
      st_reply1,
      st_reply2,
      st_reply3
   } ctrl_state_t;

   ctrl_state_t   state;
   logic          is_read;
   logic [AW-1:0] addr_q;
   word_t         wdata_q;
   word_t         rd_word;

   wire in_reply = (state == st_reply0) || (state == st_reply1) ||
                   (state == st_reply2) || (state == st_reply3);

   ////////////////////////////////
   // Strobes
   ////////////////////////////////

   // Command bytes are taken in every non-reply state
   assign cmd_pop  = !in_reply && !cmd_empty;
   assign rep_push = in_reply && !rep_full;

   // Byte 0 comes straight from the RAM, the rest from the latch
   always_comb begin
      unique case (state)
         st_reply1: rep_byte = rd_word[15:8];
         st_reply2: rep_byte = rd_word[23:16];
         st_reply3: rep_byte = rd_word[31:24];
         default:   rep_byte = mem_rdata[7:0];
      endcase
   end

   ////////////////////////////////
   // Command FSM
   ////////////////////////////////

   always_ff @(posedge sysclk or posedge reset) begin
      if (reset) begin
         state   <= st_opcode;
         is_read <= 1'b0;
         addr_q  <= '0;
         mem_we  <= 1'b0;
         trap    <= 1'b0;
      end else begin
         mem_we <= 1'b0;
         unique case (state)
            st_opcode: begin
               if (cmd_pop) begin
                  if (cmd_byte == op_write_c || cmd_byte == op_read_c) begin
                     is_read <= (cmd_byte == op_read_c);
                     state   <= st_addr;
                  end else begin
                     // Illegal opcode is dropped
                     trap <= 1'b1;
                  end
               end
            end
            st_addr: begin
               if (cmd_pop) begin
                  // Upper address bits alias
                  addr_q <= cmd_byte[AW-1:0];
                  state  <= is_read ? st_reply0 : st_data0;
               end
            end
            st_data0: if (cmd_pop) state <= st_data1;
            st_data1: if (cmd_pop) state <= st_data2;
            st_data2: if (cmd_pop) state <= st_data3;
            st_data3: begin
               if (cmd_pop) begin
                  mem_we <= 1'b1;
                  state  <= st_opcode;
               end
            end
            st_reply0: if (rep_push) state <= st_reply1;
            st_reply1: if (rep_push) state <= st_reply2;
            st_reply2: if (rep_push) state <= st_reply3;
            st_reply3: if (rep_push) state <= st_opcode;
            default: state <= st_opcode;
         endcase
      end
   end

   // Write word, LSB first
   always_ff @(posedge sysclk) begin
      if (cmd_pop) begin
         unique case (state)
            st_data0: wdata_q[7:0]   <= cmd_byte;
            st_data1: wdata_q[15:8]  <= cmd_byte;
            st_data2: wdata_q[23:16] <= cmd_byte;
            st_data3: wdata_q[31:24] <= cmd_byte;
            default: ;
         endcase
      end
   end

   always_ff @(posedge sysclk) begin
      if (state == st_reply0) begin
         rd_word <= mem_rdata;
      end
   end

   assign mem_addr  = addr_q;
   assign mem_wdata = wdata_q;

endmodule

// File: top_system.sv
`timescale 1ns/1ps

module top_system import soc_cfg_pkg::*; import cmd_pkg::*; #(
   parameter int BAUD_DIV   = baud_div_c,
   parameter int RESET_HOLD = reset_hold_c,
   parameter int DEPTH      = fifo_depth_c,
   parameter int WORDS      = mem_words_c
) (
   input  logic sysclk,
   input  logic reset,
   input  logic uart_rxd,
   output logic uart_txd,
   output logic trap
);

   logic                     sys_reset;
   byte_t                    rx_byte;
   logic                     rx_valid;
   byte_t                    cmd_byte;
   logic                     cmd_empty;
   logic                     rd_en;
   logic                     mem_we;
   logic [$clog2(WORDS)-1:0] mem_addr;
   word_t                    mem_wdata;
   word_t                    mem_rdata;
   byte_t                    rep_byte;
   logic                     push;
   logic                     rep_full;
   byte_t                    tx_byte;
   logic                     tx_empty;
   logic                     tx_pop;

   // Held reset for everything below
   por_reset #(.RESET_HOLD(RESET_HOLD)) i_por_reset (
      .sysclk    (sysclk),
      .reset     (reset),
      .sys_reset (sys_reset)
   );

   ////////////////////////////////
   // Host side
   ////////////////////////////////

   uart_rx #(.BAUD_DIV(BAUD_DIV)) i_uart_rx (
      .sysclk   (sysclk),
      .reset    (sys_reset),
      .rxd      (uart_rxd),
      .rx_byte  (rx_byte),
      .rx_valid (rx_valid)
   );

   byte_fifo #(.DEPTH(DEPTH)) rx_fifo (
      .sysclk  (sysclk),
      .reset   (sys_reset),
      .wr_data (rx_byte),
      .push    (rx_valid),
      .pop     (rd_en),
      .rd_data (cmd_byte),
      .empty   (cmd_empty),
      .full    ()
   );

   byte_fifo #(.DEPTH(DEPTH)) tx_fifo (
      .sysclk  (sysclk),
      .reset   (sys_reset),
      .wr_data (rep_byte),
      .push    (push),
      .pop     (tx_pop),
      .rd_data (tx_byte),
      .empty   (tx_empty),
      .full    (rep_full)
   );

   uart_tx #(.BAUD_DIV(BAUD_DIV)) i_uart_tx (
      .sysclk   (sysclk),
      .reset    (sys_reset),
      .tx_byte  (tx_byte),
      .tx_empty (tx_empty),
      .tx_pop   (tx_pop),
      .txd      (uart_txd)
   );

   ////////////////////////////////
   // Command engine
   ////////////////////////////////

   word_ram #(.WORDS(WORDS)) i_word_ram (
      .sysclk (sysclk),
      .reset  (sys_reset),
      .we     (mem_we),
      .addr   (mem_addr),
      .wdata  (mem_wdata),
      .rdata  (mem_rdata)
   );

   cmd_ctrl #(.WORDS(WORDS)) i_cmd_ctrl (
      .sysclk    (sysclk),
      .reset     (sys_reset),
      .cmd_byte  (cmd_byte),
      .cmd_empty (cmd_empty),
      .cmd_pop   (rd_en),
      .mem_we    (mem_we),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_rdata (mem_rdata),
      .rep_byte  (rep_byte),
      .rep_push  (push),
      .rep_full  (rep_full),
      .trap      (trap)
   );

endmodule

// File: tb_top_system.sv
`timescale 1ns/1ps

module tb_top_system import soc_cfg_pkg::*; import cmd_pkg::*; ();

   // Longest gap before a reply frame, in sysclk cycles
   localparam int rx_wait_c   = 300 * baud_div_c;
   localparam int trap_wait_c = 4 * baud_div_c;

   logic        sysclk = 1'b0;
   logic        reset;
   logic        uart_rxd;
   logic        uart_txd;
   logic        trap;
   logic [31:0] lfsr;
   word_t       model_mem [mem_words_c];
   logic        model_trap;
   word_t       exp_words [$];
   int          mismatch_cnt;
   int          fail_cnt;

   top_system #(
      .BAUD_DIV   (baud_div_c),
      .RESET_HOLD (reset_hold_c),
      .DEPTH      (fifo_depth_c),
      .WORDS      (mem_words_c)
   ) i_dut (
      .sysclk   (sysclk),
      .reset    (reset),
      .uart_rxd (uart_rxd),
      .uart_txd (uart_txd),
      .trap     (trap)
   );

   initial begin
      forever #50 sysclk = ~sysclk;
   end

   //////////////////////////////
   // Random source and checks
   //////////////////////////////

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   // One LFSR step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   task automatic check_byte(input string name, input byte_t got, input byte_t exp);
      if (got !== exp) begin
         $display("mismatch at %0t: %s got %02h expected %02h", $time, name, got, exp);
         mismatch_cnt++;
      end
   endtask

   task automatic check_trap(input logic got, input logic exp);
      if (got !== exp) begin
         $display("mismatch at %0t: trap got %b expected %b", $time, got, exp);
         mismatch_cnt++;
      end
   endtask

   task automatic check_line(input logic got, input logic exp);
      if (got !== exp) begin
         $display("mismatch at %0t: uart_txd got %b expected %b", $time, got, exp);
         mismatch_cnt++;
      end
   endtask

   task automatic watch_idle(input int cycles);
      repeat (cycles) begin
         @(negedge sysclk);
         check_line(uart_txd, 1'b1);
         check_trap(trap, model_trap);
      end
   endtask

   //////////////////////////////
   // UART host
   //////////////////////////////

   task automatic send_byte(input byte_t b);
      uart_rxd = 1'b0;
      repeat (baud_div_c) @(negedge sysclk);
      for (int i = 0; i < 8; i++) begin
         uart_rxd = b[i];
         repeat (baud_div_c) @(negedge sysclk);
      end
      uart_rxd = 1'b1;
      repeat (baud_div_c) @(negedge sysclk);
   endtask

   task automatic send_write(input byte_t addr, input word_t data);
      model_mem[addr % mem_words_c] = data;
      send_byte(op_write_c);
      send_byte(addr);
      for (int i = 0; i < 4; i++) begin
         send_byte(data[8*i +: 8]);
      end
   endtask

   task automatic send_read(input byte_t addr);
      exp_words.push_back(model_mem[addr % mem_words_c]);
      send_byte(op_read_c);
      send_byte(addr);
   endtask

   // Samples mid-bit on the falling edge
   task automatic recv_byte(output byte_t b, output logic ok);
      int waited;
      waited = 0;
      ok     = 1'b0;
      b      = '0;
      while (uart_txd !== 1'b0 && waited < rx_wait_c) begin
         @(negedge sysclk);
         waited++;
      end
      if (uart_txd !== 1'b0) begin
         $display("timeout at %0t: no start bit seen on uart_txd", $time);
         fail_cnt++;
         return;
      end
      repeat (baud_div_c / 2) @(negedge sysclk);
      if (uart_txd !== 1'b0) begin
         $display("error at %0t: start bit on uart_txd ended early", $time);
         fail_cnt++;
         return;
      end
      for (int i = 0; i < 8; i++) begin
         repeat (baud_div_c) @(negedge sysclk);
         b[i] = uart_txd;
      end
      repeat (baud_div_c) @(negedge sysclk);
      if (uart_txd !== 1'b1) begin
         $display("error at %0t: stop bit on uart_txd is missing", $time);
         fail_cnt++;
         return;
      end
      ok = 1'b1;
   endtask

   task automatic collect_replies(input int n);
      byte_t bytes [4];
      logic  ok;
      word_t exp;
      for (int r = 0; r < n; r++) begin
         for (int k = 0; k < 4; k++) begin
            recv_byte(bytes[k], ok);
            if (!ok) return;
         end
         if (exp_words.size() == 0) begin
            $display("error at %0t: reply arrived with no read outstanding", $time);
            fail_cnt++;
            return;
         end
         exp = exp_words.pop_front();
         for (int k = 0; k < 4; k++) begin
            check_byte($sformatf("uart_txd reply byte %0d", k), bytes[k], exp[8*k +: 8]);
         end
      end
   endtask

   task automatic wait_trap();
      int waited;
      waited = 0;
      while (trap !== 1'b1 && waited < trap_wait_c) begin
         @(negedge sysclk);
         waited++;
      end
      if (trap !== 1'b1) begin
         $display("timeout at %0t: trap did not rise after an unknown opcode", $time);
         fail_cnt++;
      end
   endtask

   //////////////////////////////
   // Test sequence
   //////////////////////////////

   initial begin
      byte_t a;
      byte_t op;
      word_t d;
      reset        = 1'b1;
      uart_rxd     = 1'b1;
      lfsr         = 32'hada0_f7f1;
      model_trap   = 1'b0;
      mismatch_cnt = 0;
      fail_cnt     = 0;
      for (int i = 0; i < mem_words_c; i++) begin
         model_mem[i] = '0;
      end

      // Quiet line through reset and the hold time
      watch_idle(3);
      reset = 1'b0;
      watch_idle(reset_hold_c + 4 * baud_div_c);

      // Fresh memory reads zero
      repeat (3) begin
         a = byte_t'(rand_bits(8));
         fork
            send_read(a);
            collect_replies(1);
         join
      end

      repeat (12) begin
         a = byte_t'(rand_bits(8));
         d = rand_bits(32);
         send_write(a, d);
      end
      watch_idle(12 * baud_div_c);
      repeat (16) begin
         a = byte_t'(rand_bits(8));
         fork
            send_read(a);
            collect_replies(1);
         join
      end

      // Aliased address reaches the same word
      repeat (4) begin
         a = byte_t'(rand_bits(4));
         send_write(a, rand_bits(32));
         a = a + byte_t'(mem_words_c * (1 + rand_bits(3)));
         fork
            send_read(a);
            collect_replies(1);
         join
      end
      check_trap(trap, model_trap);

      op = byte_t'(rand_bits(8));
      while (op == op_write_c || op == op_read_c) begin
         op = byte_t'(rand_bits(8));
      end
      send_byte(op);
      model_trap = 1'b1;
      wait_trap();
      repeat (4) begin
         send_write(byte_t'(rand_bits(8)), rand_bits(32));
      end
      repeat (4) begin
         a = byte_t'(rand_bits(8));
         fork
            send_read(a);
            collect_replies(1);
         join
      end
      check_trap(trap, model_trap);

      // Write straight into a read of the same word
      repeat (4) begin
         a = byte_t'(rand_bits(8));
         d = rand_bits(32);
         fork
            begin
               send_write(a, d);
               send_read(a ^ byte_t'(mem_words_c * rand_bits(4)));
            end
            collect_replies(1);
         join
      end

      repeat (3) begin
         fork
            repeat (3) send_read(byte_t'(rand_bits(8)));
            collect_replies(3);
         join
      end
      watch_idle(4 * baud_div_c);

      if (exp_words.size() != 0) begin
         $display("error: %0d read replies never arrived", exp_words.size());
         fail_cnt++;
      end
      $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
      if (mismatch_cnt == 0 && fail_cnt == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// File: compile.f
soc_cfg_pkg.sv
cmd_pkg.sv
por_reset.sv
uart_rx.sv
uart_tx.sv
byte_fifo.sv
word_ram.sv
cmd_ctrl.sv
top_system.sv
tb_top_system.sv

// File: Bender.yml
package:
  name: top_system

sources:
  - soc_cfg_pkg.sv
  - cmd_pkg.sv
  - por_reset.sv
  - uart_rx.sv
  - uart_tx.sv
  - byte_fifo.sv
  - word_ram.sv
  - cmd_ctrl.sv
  - top_system.sv
  - target: test
    files:
      - tb_top_system.sv
